//--- ahbl_aout_regs.sv
`timescale 1ns/100ps

// AHB-Lite register block for the audio output path
// Control/status register, FIFO write port and FIFO level interrupt

module ahbl_aout_regs (
    input  logic                                clk_sys,
    input  logic                                rst_n_sys,

    // AHB-Lite slave port
    input  logic [apu_aout_pkg::W_HADDR-1:0]    haddr_i,
    input  logic [1:0]                          htrans_i,
    input  logic                                hwrite_i,
    input  logic [2:0]                          hsize_i,
    input  logic                                hready_i,
    input  logic [31:0]                         hwdata_i,
    output logic                                hready_resp_o,
    output logic                                hresp_o,
    output logic [31:0]                         hrdata_o,

    // Status from FIFO and player
    input  logic                                fifo_full_i,
    input  logic [apu_aout_pkg::W_FLEVEL-1:0]   fifo_level_i,
    input  logic                                running_i,

    // FIFO write port
    output logic                                fifo_push_o,
    output apu_aout_pkg::aout_sample_u          fifo_wdata_o,

    // Player control and interrupt
    output logic                                enable_o,
    output logic [apu_aout_pkg::W_INTERVAL-1:0] interval_o,
    output logic                                irq_o
);

    import apu_aout_pkg::*;

    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // Captured address phase
    logic               ap_valid;
    logic               ap_write;
    logic [W_HADDR-1:0] ap_addr;

    // CSR fields
    logic                  enable_q;
    logic                  signed_q;
    logic [W_FLEVEL-1:0]   irqlevel_q;
    logic [W_INTERVAL-1:0] interval_q;
    logic                  irq_q;

    logic        wr_csr;
    logic        wr_fifo;
    logic        rd_csr;
    logic [31:0] csr_rdata;

    // --------------------------------------------------
    // Bus pipeline

    // Zero wait states and never an error
    assign hready_resp_o = 1'b1;
    assign hresp_o       = 1'b0;

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            ap_valid <= 1'b0;
            ap_write <= 1'b0;
            ap_addr  <= '0;
        end else if (hready_i) begin
            ap_valid <= htrans_i[1];
            ap_write <= hwrite_i;
            ap_addr  <= haddr_i;
        end
    end

    // Data phase decode
    assign wr_csr  = ap_valid && ap_write && (ap_addr == ADDR_CSR);
    assign wr_fifo = ap_valid && ap_write && (ap_addr == ADDR_FIFO);
    assign rd_csr  = ap_valid && !ap_write && (ap_addr == ADDR_CSR);

    // --------------------------------------------------
    // Control/status register

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            enable_q   <= 1'b0;
            signed_q   <= 1'b0;
            irqlevel_q <= '0;
            interval_q <= '0;
        end else if (wr_csr) begin
            enable_q   <= hwdata_i[CSR_ENABLE];
            signed_q   <= hwdata_i[CSR_SIGNED];
            irqlevel_q <= hwdata_i[CSR_IRQLEVEL_LSB +: W_FLEVEL];
            interval_q <= hwdata_i[CSR_INTERVAL_LSB +: W_INTERVAL];
        end
    end

    always_comb begin
        csr_rdata                                    = '0;
        csr_rdata[CSR_ENABLE]                        = enable_q;
        csr_rdata[CSR_RUNNING]                       = running_i;
        csr_rdata[CSR_SIGNED]                        = signed_q;
        csr_rdata[CSR_RDY]                           = !fifo_full_i;
        csr_rdata[CSR_FLEVEL_LSB +: W_FLEVEL]        = fifo_level_i;
        csr_rdata[CSR_IRQLEVEL_LSB +: W_FLEVEL]      = irqlevel_q;
        csr_rdata[CSR_INTERVAL_LSB +: W_INTERVAL]    = interval_q;
    end

    // FIFO offset and unmapped offsets read as zero
    assign hrdata_o = rd_csr ? csr_rdata : 32'd0;

    assign enable_o   = enable_q;
    assign interval_o = interval_q;

    // --------------------------------------------------
    // FIFO write port

    // Full FIFO drops the word inside the FIFO itself
    assign fifo_push_o = wr_fifo;

    // Two's complement to offset binary by flipping each sign bit
    always_comb begin
        fifo_wdata_o.raw = hwdata_i;
        fifo_wdata_o.pair.left[W_SAMPLE-1] =
            hwdata_i[2*W_SAMPLE-1] ^ signed_q;
        fifo_wdata_o.pair.right[W_SAMPLE-1] =
            hwdata_i[W_SAMPLE-1] ^ signed_q;
    end

    // --------------------------------------------------
    // Level interrupt

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (fifo_level_i <= irqlevel_q);
        end
    end

    assign irq_o = irq_q;

    // Only word transfers are defined for this block
    a_word_size: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        (htrans_i[1] && hready_i) |-> (hsize_i == HSIZE_WORD)
    );

endmodule

//--- aout_player.sv
`timescale 1ns/100ps

// Audio sample player
// Times the sample periods, pops the FIFO and drives both PDM channels

module aout_player #(
    parameter int TICKS_PER_STEP = 16
) (
    input  logic                                clk_sys,
    input  logic                                rst_n_sys,

    input  logic                                enable_i,
    input  logic [apu_aout_pkg::W_INTERVAL-1:0] interval_i,

    input  logic                                fifo_empty_i,
    input  apu_aout_pkg::aout_sample_u          fifo_rdata_i,
    output logic                                fifo_pop_o,

    output logic                                running_o,

    output logic                                audio_l_o,
    output logic                                audio_r_o
);

    import apu_aout_pkg::*;

    localparam int W_PRESC = $clog2(TICKS_PER_STEP + 1);

    logic                  running_q;
    logic [W_PRESC-1:0]    step_cnt;
    logic [W_INTERVAL-1:0] interval_cnt;
    logic                  step_tick;
    logic                  period_end;
    aout_sample_u          hold_q;

    // --------------------------------------------------
    // Enable and period timing

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            running_q <= 1'b0;
        end else begin
            running_q <= enable_i;
        end
    end

    assign running_o = running_q;

    assign step_tick  = (step_cnt == W_PRESC'(TICKS_PER_STEP - 1));
    // >= keeps the count bounded if INTERVAL shrinks mid-period
    assign period_end = step_tick && (interval_cnt >= interval_i);

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            step_cnt     <= '0;
            interval_cnt <= '0;
        end else if (!running_q) begin
            step_cnt     <= '0;
            interval_cnt <= '0;
        end else if (step_tick) begin
            step_cnt     <= '0;
            interval_cnt <= period_end ? '0 : interval_cnt + 1'b1;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Sample hold

    // Empty FIFO at period end repeats the held sample
    assign fifo_pop_o = period_end && !fifo_empty_i;

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            hold_q <= '0;
        end else if (!running_q) begin
            hold_q <= '0;
        end else if (fifo_pop_o) begin
            hold_q <= fifo_rdata_i;
        end
    end

    // --------------------------------------------------
    // Output channels

    aout_sdm_channel u_sdm_l (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .clear_i   (!running_q),
        .sample_i  (hold_q.pair.left),
        .pdm_o     (audio_l_o)
    );

    aout_sdm_channel u_sdm_r (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .clear_i   (!running_q),
        .sample_i  (hold_q.pair.right),
        .pdm_o     (audio_r_o)
    );

endmodule

//--- aout_sdm_channel.sv
`timescale 1ns/100ps

// First-order sigma-delta modulator for one audio channel
// Accumulator carry gives a one-bit pulse-density output

module aout_sdm_channel (
    input  logic                              clk_sys,
    input  logic                              rst_n_sys,

    input  logic                              clear_i,
    input  logic [apu_aout_pkg::W_SAMPLE-1:0] sample_i,

    output logic                              pdm_o
);

    import apu_aout_pkg::*;

    logic [W_SAMPLE-1:0] acc;
    logic                pdm_q;
    logic [W_SAMPLE:0]   sum;

    // Carry out of the add is the density bit
    assign sum = {1'b0, acc} + {1'b0, sample_i};

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            acc   <= '0;
            pdm_q <= 1'b0;
        end else if (clear_i) begin
            acc   <= '0;
            pdm_q <= 1'b0;
        end else begin
            acc   <= sum[W_SAMPLE-1:0];
            pdm_q <= sum[W_SAMPLE];
        end
    end

    assign pdm_o = pdm_q;

endmodule

//--- apu_aout_pkg.sv
// Shared definitions for the audio output path
// Register map, CSR field positions and the stereo sample word

package apu_aout_pkg;

    // --------------------------------------------------
    // Widths

    localparam int W_SAMPLE   = 16;
    localparam int W_HADDR    = 16;
    localparam int W_FLEVEL   = 3;
    localparam int W_INTERVAL = 8;

    // --------------------------------------------------
    // Register map, word offsets

    localparam logic [W_HADDR-1:0] ADDR_CSR  = 16'h0000;
    localparam logic [W_HADDR-1:0] ADDR_FIFO = 16'h0004;

    // --------------------------------------------------
    // CSR field positions

    localparam int CSR_ENABLE       = 0;
    // Read-only, player state
    localparam int CSR_RUNNING      = 1;
    localparam int CSR_SIGNED       = 2;
    // Read-only, set while the FIFO can take another word
    localparam int CSR_RDY          = 3;
    localparam int CSR_FLEVEL_LSB   = 8;
    localparam int CSR_IRQLEVEL_LSB = 12;
    localparam int CSR_INTERVAL_LSB = 16;

    // --------------------------------------------------
    // Stereo sample word

    // Left channel in the upper half, right channel in the lower half
    typedef union packed {
        logic [2*W_SAMPLE-1:0] raw;
        struct packed {
            logic [W_SAMPLE-1:0] left;
            logic [W_SAMPLE-1:0] right;
        } pair;
    } aout_sample_u;

endpackage

//--- apu_aout_top.sv
`timescale 1ns/100ps

// Audio output path top level
// AHB-Lite register block, sample FIFO and PDM player

module apu_aout_top #(
    parameter int FIFO_DEPTH     = 4,
    parameter int TICKS_PER_STEP = 16
) (
    input  logic                             clk_sys,
    input  logic                             rst_n_sys,

    input  logic [apu_aout_pkg::W_HADDR-1:0] haddr_i,
    input  logic [1:0]                       htrans_i,
    input  logic                             hwrite_i,
    input  logic [2:0]                       hsize_i,
    input  logic                             hready_i,
    input  logic [31:0]                      hwdata_i,
    output logic                             hready_resp_o,
    output logic                             hresp_o,
    output logic [31:0]                      hrdata_o,

    output logic                             irq_o,
    output logic                             audio_l_o,
    output logic                             audio_r_o
);

    import apu_aout_pkg::*;

    logic                  fifo_push;
    aout_sample_u          fifo_wdata;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic [W_FLEVEL-1:0]   fifo_level;
    logic                  fifo_pop;
    aout_sample_u          fifo_rdata;
    logic                  enable;
    logic [W_INTERVAL-1:0] interval;
    logic                  running;

    ahbl_aout_regs u_regs (
        .clk_sys       (clk_sys),
        .rst_n_sys     (rst_n_sys),
        .haddr_i       (haddr_i),
        .htrans_i      (htrans_i),
        .hwrite_i      (hwrite_i),
        .hsize_i       (hsize_i),
        .hready_i      (hready_i),
        .hwdata_i      (hwdata_i),
        .hready_resp_o (hready_resp_o),
        .hresp_o       (hresp_o),
        .hrdata_o      (hrdata_o),
        .fifo_full_i   (fifo_full),
        .fifo_level_i  (fifo_level),
        .running_i     (running),
        .fifo_push_o   (fifo_push),
        .fifo_wdata_o  (fifo_wdata),
        .enable_o      (enable),
        .interval_o    (interval),
        .irq_o         (irq_o)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .push_i    (fifo_push),
        .wdata_i   (fifo_wdata),
        .pop_i     (fifo_pop),
        .rdata_o   (fifo_rdata),
        .full_o    (fifo_full),
        .empty_o   (fifo_empty),
        .level_o   (fifo_level)
    );

    aout_player #(
        .TICKS_PER_STEP (TICKS_PER_STEP)
    ) u_player (
        .clk_sys      (clk_sys),
        .rst_n_sys    (rst_n_sys),
        .enable_i     (enable),
        .interval_i   (interval),
        .fifo_empty_i (fifo_empty),
        .fifo_rdata_i (fifo_rdata),
        .fifo_pop_o   (fifo_pop),
        .running_o    (running),
        .audio_l_o    (audio_l_o),
        .audio_r_o    (audio_r_o)
    );

endmodule

//--- build.f
apu_aout_pkg.sv
ahbl_aout_regs.sv
sample_fifo.sv
aout_sdm_channel.sv
aout_player.sv
apu_aout_top.sv
tb_apu_aout.sv

//--- sample_fifo.sv
`timescale 1ns/100ps

// Synchronous stereo sample FIFO
// Register array with read/write pointers and a level counter

module sample_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                              clk_sys,
    input  logic                              rst_n_sys,

    input  logic                              push_i,
    input  apu_aout_pkg::aout_sample_u        wdata_i,

    input  logic                              pop_i,
    output apu_aout_pkg::aout_sample_u        rdata_o,

    output logic                              full_o,
    output logic                              empty_o,
    output logic [apu_aout_pkg::W_FLEVEL-1:0] level_o
);

    import apu_aout_pkg::*;

    // Depth is a power of two so the pointers wrap on their own
    localparam int W_PTR = $clog2(FIFO_DEPTH);

    aout_sample_u        mem [FIFO_DEPTH];
    logic [W_PTR-1:0]    wr_ptr;
    logic [W_PTR-1:0]    rd_ptr;
    logic [W_FLEVEL-1:0] level;
    logic                do_push;
    logic                do_pop;

    assign full_o  = (level == W_FLEVEL'(FIFO_DEPTH));
    assign empty_o = (level == '0);
    assign level_o = level;

    // Push while full and pop while empty are ignored
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    assign rdata_o = mem[rd_ptr];

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    a_level_bound: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        level <= W_FLEVEL'(FIFO_DEPTH)
    );

    // Player must check empty before it pops
    a_no_pop_empty: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        pop_i |-> !empty_o
    );

endmodule

//--- tb_apu_aout.sv
`timescale 1ns/100ps

// Directed testbench for the audio output path
// Bus tasks, five tests and a closing report

module tb_apu_aout;

    localparam logic [15:0] A_CSR  = 16'h0000;
    localparam logic [15:0] A_FIFO = 16'h0004;

    logic        clk_sys;
    logic        rst_n_sys;
    logic [15:0] haddr_i;
    logic [1:0]  htrans_i;
    logic        hwrite_i;
    logic [2:0]  hsize_i;
    logic        hready_i;
    logic [31:0] hwdata_i;
    logic        hready_resp_o;
    logic        hresp_o;
    logic [31:0] hrdata_o;
    logic        irq_o;
    logic        audio_l_o;
    logic        audio_r_o;

    logic [31:0] lfsr_state;
    int          test_errors;
    int          total_errors;
    int          failed_tests;

    apu_aout_top DUT (
        .clk_sys       (clk_sys),
        .rst_n_sys     (rst_n_sys),
        .haddr_i       (haddr_i),
        .htrans_i      (htrans_i),
        .hwrite_i      (hwrite_i),
        .hsize_i       (hsize_i),
        .hready_i      (hready_i),
        .hwdata_i      (hwdata_i),
        .hready_resp_o (hready_resp_o),
        .hresp_o       (hresp_o),
        .hrdata_o      (hrdata_o),
        .irq_o         (irq_o),
        .audio_l_o     (audio_l_o),
        .audio_r_o     (audio_r_o)
    );

    always #4 clk_sys = ~clk_sys;

    // --------------------------------------------------
    // Helpers

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_half(output logic [15:0] v);
        v = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] csr_word(input logic en, run, sgn, rdy,
                                             input logic [2:0] flevel, irqlvl,
                                             input logic [7:0] interval);
        csr_word        = '0;
        csr_word[0]     = en;
        csr_word[1]     = run;
        csr_word[2]     = sgn;
        csr_word[3]     = rdy;
        csr_word[10:8]  = flevel;
        csr_word[14:12] = irqlvl;
        csr_word[23:16] = interval;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic check_near(input string name, input int actual, input int expected);
        assert (actual >= expected - 1 && actual <= expected + 1) else begin
            $display("** Error at %0t: %s = %0d, expected %0d +/- 1",
                     $time, name, actual, expected);
            test_errors++;
        end
    endtask

    // Address phase, then data phase, then the cycle where it takes effect
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clk_sys);
        haddr_i  <= addr;
        htrans_i <= 2'b10;
        hwrite_i <= 1'b1;
        @(posedge clk_sys);
        htrans_i <= 2'b00;
        hwrite_i <= 1'b0;
        hwdata_i <= data;
        @(posedge clk_sys);
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        @(posedge clk_sys);
        haddr_i  <= addr;
        htrans_i <= 2'b10;
        hwrite_i <= 1'b0;
        @(posedge clk_sys);
        htrans_i <= 2'b00;
        @(negedge clk_sys);
        data = hrdata_o;
        @(posedge clk_sys);
    endtask

    task automatic check_irq(input logic expected);
        @(negedge clk_sys);
        check_eq("irq_o", irq_o, expected);
    endtask

    task automatic check_quiet(input int cycles);
        bit bad;
        bad = 0;
        for (int i = 0; i < cycles && !bad; i++) begin
            @(negedge clk_sys);
            assert ({audio_l_o, audio_r_o} == 2'b00) else begin
                $display("** Error at %0t: {audio_l_o, audio_r_o} = %b, expected 00",
                         $time, {audio_l_o, audio_r_o});
                test_errors++;
                bad = 1;
            end
        end
    endtask

    task automatic wait_level_zero(input int max_cycles);
        logic [31:0] rd;
        int          waited;
        bit          drained;
        waited  = 0;
        drained = 0;
        while (!drained && waited < max_cycles) begin
            bus_read(A_CSR, rd);
            waited += 3;
            drained = (rd[10:8] == 3'd0);
        end
        assert (drained) else begin
            $display("FIFO did not drain within %0d cycles", max_cycles);
            test_errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // --------------------------------------------------
    // Tests

    task automatic test_reset_state();
        logic [31:0] rd;
        bus_read(A_CSR, rd);
        check_eq("csr", rd, csr_word(0, 0, 0, 1, 3'd0, 3'd0, 8'h00));
        check_irq(1'b1);
        check_eq("hresp_o", hresp_o, 1'b0);
        check_eq("hready_resp_o", hready_resp_o, 1'b1);
        check_quiet(100);
        end_test(1, "reset state");
    endtask

    task automatic test_register_access();
        logic [31:0] rd;
        // Read-only fields written with junk
        bus_write(A_CSR, csr_word(0, 1, 1, 0, 3'd7, 3'd5, 8'hA5));
        bus_read(A_CSR, rd);
        check_eq("csr", rd, csr_word(0, 0, 1, 1, 3'd0, 3'd5, 8'hA5));
        bus_write(A_CSR, csr_word(1, 0, 0, 0, 3'd0, 3'd2, 8'h3C));
        bus_read(A_CSR, rd);
        check_eq("csr", rd, csr_word(1, 1, 0, 1, 3'd0, 3'd2, 8'h3C));
        bus_write(A_CSR, 32'd0);
        bus_read(A_FIFO, rd);
        check_eq("hrdata_o fifo", rd, 32'd0);
        bus_read(16'h0008, rd);
        check_eq("hrdata_o unmapped", rd, 32'd0);
        bus_read(16'h0040, rd);
        check_eq("hrdata_o unmapped", rd, 32'd0);
        end_test(2, "register access");
    endtask

    task automatic test_fifo_irq();
        logic [31:0] rd;
        logic [15:0] l;
        logic [15:0] r;
        bus_write(A_CSR, csr_word(0, 0, 0, 0, 3'd0, 3'd2, 8'h00));
        for (int i = 1; i <= 5; i++) begin
            random_half(l);
            random_half(r);
            bus_write(A_FIFO, {l, r});
            bus_read(A_CSR, rd);
            // Fifth write is dropped
            check_eq("csr.flevel", rd[10:8], (i > 4) ? 4 : i);
            check_eq("csr.rdy", rd[3], (i < 4));
            check_irq(((i > 4) ? 4 : i) <= 2);
        end
        bus_write(A_CSR, csr_word(0, 0, 0, 0, 3'd0, 3'd4, 8'h00));
        repeat (2) @(posedge clk_sys);
        check_irq(1'b1);
        // Drain with the shortest interval
        bus_write(A_CSR, csr_word(1, 0, 0, 0, 3'd0, 3'd4, 8'h00));
        wait_level_zero(128);
        bus_write(A_CSR, 32'd0);
        end_test(3, "FIFO and interrupt");
    endtask

    task automatic test_playback_drain();
        logic [31:0] rd;
        logic [15:0] l;
        logic [15:0] r;
        bus_write(A_CSR, csr_word(0, 0, 0, 0, 3'd0, 3'd0, 8'h01));
        repeat (3) begin
            random_half(l);
            random_half(r);
            bus_write(A_FIFO, {l, r});
        end
        bus_read(A_CSR, rd);
        check_eq("csr.flevel", rd[10:8], 3'd3);
        bus_write(A_CSR, csr_word(1, 0, 0, 0, 3'd0, 3'd0, 8'h01));
        bus_read(A_CSR, rd);
        check_eq("csr.running", rd[1], 1'b1);
        // Four periods of 32 cycles
        wait_level_zero(128);
        repeat (4) begin
            repeat (16) @(posedge clk_sys);
            bus_read(A_CSR, rd);
            check_eq("csr.flevel", rd[10:8], 3'd0);
        end
        bus_write(A_CSR, csr_word(0, 0, 0, 0, 3'd0, 3'd0, 8'h01));
        bus_read(A_CSR, rd);
        check_eq("csr.running", rd[1], 1'b0);
        check_quiet(64);
        end_test(4, "playback drain");
    endtask

    task automatic play_constant(input logic sgn, input logic [15:0] l, r);
        int ones_l;
        int ones_r;
        int sl;
        int sr;
        bus_write(A_CSR, csr_word(0, 0, sgn, 0, 3'd0, 3'd0, 8'hFF));
        bus_write(A_FIFO, {l, r});
        bus_write(A_CSR, csr_word(1, 0, sgn, 0, 3'd0, 3'd0, 8'hFF));
        wait_level_zero(4096 + 256);
        ones_l = 0;
        ones_r = 0;
        repeat (1024) begin
            @(negedge clk_sys);
            ones_l += audio_l_o;
            ones_r += audio_r_o;
        end
        // Signed samples go in with the sign bit flipped
        sl = sgn ? (l ^ 16'h8000) : l;
        sr = sgn ? (r ^ 16'h8000) : r;
        check_near("audio_l_o ones", ones_l, (1024 * sl) / 65536);
        check_near("audio_r_o ones", ones_r, (1024 * sr) / 65536);
        bus_write(A_CSR, csr_word(0, 0, 0, 0, 3'd0, 3'd0, 8'hFF));
    endtask

    task automatic test_pulse_density();
        logic [15:0] l;
        logic [15:0] r;
        random_half(l);
        random_half(r);
        play_constant(1'b0, l, r);
        play_constant(1'b1, l, r);
        end_test(5, "pulse density and signed");
    endtask

    // --------------------------------------------------
    // Main sequence

    initial begin
        clk_sys      = 1'b0;
        rst_n_sys    = 1'b0;
        haddr_i      = '0;
        htrans_i     = 2'b00;
        hwrite_i     = 1'b0;
        hsize_i      = 3'b010;
        hready_i     = 1'b1;
        hwdata_i     = '0;
        lfsr_state   = 32'he434_1b63;
        test_errors  = 0;
        total_errors = 0;
        failed_tests = 0;
        repeat (8) @(posedge clk_sys);
        rst_n_sys <= 1'b1;
        repeat (2) @(posedge clk_sys);

        test_reset_state();
        test_register_access();
        test_fifo_irq();
        test_playback_drain();
        test_pulse_density();

        $display("Tests run: 5, tests failed: %0d, checks failed: %0d",
                 failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Whole-run limit
    initial begin
        #500_000;
        $display("Run timed out before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
